//--- design/ahb_pkg.sv
/*
  AHB-Lite slave port definitions
  - bus data width and HPROT bit positions
  - HTRANS and HSIZE encodings
  - address-phase input bundle
*/
package ahb_pkg;

  // ----------------------------------------
  // Widths and bit positions
  // ----------------------------------------
  localparam int data_width = 32;    // HWDATA / HRDATA / PWDATA / PRDATA

  localparam int hprot_data_bit = 0; // HPROT[0]: 0 opcode fetch, 1 data
  localparam int hprot_priv_bit = 1; // HPROT[1]: 0 user, 1 privileged

  // ----------------------------------------
  // Encodings
  // ----------------------------------------
  typedef enum logic [1:0] {
    trans_idle   = 2'b00,  // No transfer
    trans_busy   = 2'b01,  // Burst pause, no data
    trans_nonseq = 2'b10,  // Single or first beat
    trans_seq    = 2'b11   // Remaining beats of a burst
  } htrans_e;

  // Only sizes up to the bus width are meaningful on a 32-bit port
  typedef enum logic [2:0] {
    size_byte = 3'b000,
    size_half = 3'b001,
    size_word = 3'b010
  } hsize_e;

  // ----------------------------------------
  // Address phase bundle
  // ----------------------------------------
  // Sampled by the bridge on the HCLK edge that ends the address phase
  typedef struct packed {
    logic        sel;    // HSEL from the decoder
    logic [31:0] addr;   // Full HADDR, bridge keeps the low bits only
    htrans_e     trans;
    hsize_e      size;
    logic [3:0]  prot;
    logic        write;  // 1 write, 0 read
    logic        ready;  // HREADY, previous data phase done
  } ahb_addr_phase_t;

endpackage

//--- design/apb_pkg.sv
/*
  APB master side definitions
  - bridge sequencing states and the unused code
  - captured transfer descriptor
  - APB request and response bundles
*/
package apb_pkg;

  // ----------------------------------------
  // Bridge state encoding
  // ----------------------------------------
  typedef enum logic [2:0] {
    st_idle       = 3'b000,  // No transfer pending
    st_apb_wait   = 3'b001,  // Transfer taken, waiting for pclken
    st_apb_setup  = 3'b010,  // APB setup phase, psel only
    st_apb_access = 3'b011,  // APB access phase, psel and penable
    st_end_okay   = 3'b100,  // Registered OKAY ending
    st_err_first  = 3'b101,  // ERROR, hreadyout low
    st_err_second = 3'b110   // ERROR, hreadyout high
  } bridge_state_e;

  localparam logic [2:0] st_illegal_code = 3'b111;  // Never reachable

  // ----------------------------------------
  // Bundles
  // ----------------------------------------
  typedef struct packed {
    logic [29:0] word_addr;  // HADDR[..:2], zero extended
    logic        write;
    logic [3:0]  strb;       // Byte lanes, zero on reads
    logic [2:0]  prot;       // {instruction, 0, privileged}
  } apb_xfer_t;

  typedef struct packed {
    logic [31:0]                     paddr;
    logic                            psel;
    logic                            penable;
    logic                            pwrite;
    logic [3:0]                      pstrb;
    logic [2:0]                      pprot;
    logic [ahb_pkg::data_width-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [ahb_pkg::data_width-1:0] prdata;
    logic                            pready;   // Ends the access phase
    logic                            pslverr;  // Valid with pready
  } apb_rsp_t;

endpackage

//--- design/ahb_addr_capture.sv
/*
  AHB address-phase capture
  - start decode and write-data-first flag
  - byte strobe and protection mapping
  - transfer descriptor register
*/
module ahb_addr_capture import ahb_pkg::*, apb_pkg::*; #(
  parameter int addr_width     = 16,
  parameter int register_wdata = 0
) (
  input  logic            HCLK,
  input  logic            HRESETn,
  input  ahb_addr_phase_t ahb,
  output logic            select,       // One-cycle transfer start
  output logic            wdata_first,  // Write that needs HWDATA sampled first
  output apb_xfer_t       xfer
);

  logic [3:0] strb_nxt;  // Lanes for the transfer in address phase
  logic [2:0] prot_nxt;

  // NONSEQ or SEQ, selected, and bus ready
  assign select      = ahb.sel & ahb.trans[1] & ahb.ready;
  assign wdata_first = select & ahb.write & (register_wdata != 0);

  // ----------------------------------------
  // Strobe and protection mapping
  // ----------------------------------------
  always_comb
  begin
    case (ahb.size)
      size_byte : strb_nxt = 4'b0001 << ahb.addr[1:0];          // One lane
      size_half : strb_nxt = ahb.addr[1] ? 4'b1100 : 4'b0011;   // Lane pair
      default   : strb_nxt = 4'b1111;                           // Word
    endcase
    if (!ahb.write)
      strb_nxt = 4'b0000;  // Reads carry no strobes
  end

  assign prot_nxt[0] = ahb.prot[hprot_priv_bit];   // Privileged
  assign prot_nxt[1] = 1'b0;                       // Secure
  assign prot_nxt[2] = ~ahb.prot[hprot_data_bit];  // Instruction fetch

  // ----------------------------------------
  // Descriptor register
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      xfer <= '0;
    else if (select)  // End of AHB address phase
    begin
      xfer.word_addr <= 30'(ahb.addr[addr_width-1:2]);
      xfer.write     <= ahb.write;
      xfer.strb      <= strb_nxt;
      xfer.prot      <= prot_nxt;
    end
  end

  // A captured read reaches APB with no strobes set
  a_read_no_strb : assert property (@(posedge HCLK) disable iff (!HRESETn)
    select && !ahb.write |=> !xfer.write && xfer.strb == 4'b0000)
    else $error("read captured with byte strobes set");

endmodule

//--- design/apb_transfer_fsm.sv
/*
  Bridge sequencer
  - wait, setup, access, OKAY ending and two-cycle ERROR
  - APB phase controls and AHB ready and response
*/
module apb_transfer_fsm import apb_pkg::*; #(
  parameter int register_rdata = 1
) (
  input  logic     HCLK,
  input  logic     HRESETn,
  input  logic     select,       // Transfer start from capture stage
  input  logic     wdata_first,  // HWDATA must be registered before setup
  input  logic     pclken,
  input  apb_rsp_t rsp,
  output logic     psel,
  output logic     penable,
  output logic     hreadyout,
  output logic     hresp,
  output logic     access_done,  // Access phase completes this edge
  output logic     busy          // Any state but idle
);

  bridge_state_e state;
  bridge_state_e state_nxt;
  bridge_state_e start_state;  // Where a new transfer enters

  // ----------------------------------------
  // Start decode
  // ----------------------------------------
  // Used from every state that can accept a new address phase
  always_comb
  begin
    if (!select)
      start_state = st_idle;
    else if (pclken && !wdata_first)
      start_state = st_apb_setup;  // Straight into setup
    else
      start_state = st_apb_wait;   // Hold for pclken or write data
  end

  assign access_done = (state == st_apb_access) & rsp.pready & pclken;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle,
      st_end_okay,
      st_err_second :
        state_nxt = start_state;
      st_apb_wait :
        if (pclken)
          state_nxt = st_apb_setup;
      st_apb_setup :
        if (pclken)
          state_nxt = st_apb_access;
      st_apb_access :
      begin
        if (access_done)
        begin
          if (rsp.pslverr)
            state_nxt = st_err_first;  // Two-cycle ERROR on AHB
          else if (register_rdata != 0)
            state_nxt = st_end_okay;   // Data goes out from the register
          else if (select)
            state_nxt = st_apb_wait;   // Back-to-back, OKAY given in access
          else
            state_nxt = st_idle;
        end
      end
      st_err_first :
        state_nxt = st_err_second;
      default :
        state_nxt = st_idle;  // Recover from the unused code
    endcase
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      state <= st_idle;
    else
      state <= state_nxt;
  end

  // ----------------------------------------
  // Output decode
  // ----------------------------------------
  assign psel    = (state == st_apb_setup) | (state == st_apb_access);
  assign penable = (state == st_apb_access);
  assign hresp   = (state == st_err_first) | (state == st_err_second);
  assign busy    = (state != st_idle);

  always_comb
  begin
    case (state)
      st_idle       : hreadyout = 1'b1;
      st_apb_wait   : hreadyout = 1'b0;
      st_apb_setup  : hreadyout = 1'b0;
      // Unregistered read data ends the AHB data phase here
      st_apb_access : hreadyout = (register_rdata == 0) & access_done & ~rsp.pslverr;
      st_end_okay   : hreadyout = 1'b1;
      st_err_first  : hreadyout = 1'b0;  // First ERROR cycle
      st_err_second : hreadyout = 1'b1;
      default       : hreadyout = 1'b1;
    endcase
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_no_illegal_state : assert property (@(posedge HCLK) disable iff (!HRESETn)
    state != st_illegal_code)
    else $error("bridge FSM reached unused state code");

  // Every access phase follows a setup phase of the same transfer
  a_enable_after_select : assert property (@(posedge HCLK) disable iff (!HRESETn)
    penable |-> psel && $past(psel))
    else $error("penable without preceding setup phase");

endmodule

//--- design/bridge_data_regs.sv
/*
  Bridge data path
  - write-data sampling flag
  - shared read/write data register
  - pwdata and hrdata selection
*/
module bridge_data_regs import ahb_pkg::*; #(
  parameter int register_rdata = 1,
  parameter int register_wdata = 0
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  wdata_first,  // Write address phase accepted
  input  logic                  access_done,
  input  logic                  pclken,
  input  logic [data_width-1:0] hwdata,
  input  logic [data_width-1:0] prdata,
  output logic [data_width-1:0] pwdata,
  output logic [data_width-1:0] hrdata
);

  logic                  wdata_pending;  // HWDATA valid, not yet sampled
  logic [data_width-1:0] rw_data;        // One register serves both directions

  // ----------------------------------------
  // Write data flag
  // ----------------------------------------
  // Set in the address phase, cleared on the next pclken edge
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      wdata_pending <= 1'b0;
    else if (wdata_first)
      wdata_pending <= 1'b1;
    else if (wdata_pending && pclken)
      wdata_pending <= 1'b0;
  end

  // ----------------------------------------
  // Data register
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (wdata_pending && pclken && register_wdata != 0)
      rw_data <= hwdata;   // Write data held for the APB transfer
    else if (access_done && register_rdata != 0)
      rw_data <= prdata;   // Read data held for the ending cycle
  end

  assign pwdata = (register_wdata != 0) ? rw_data : hwdata;
  assign hrdata = (register_rdata != 0) ? rw_data : prdata;

endmodule

//--- design/ahb_to_apb_bridge.sv
/*
  AHB-Lite to APB bridge top
  - capture stage, sequencer and data registers
  - APB request assembly and apbactive
*/
module ahb_to_apb_bridge import ahb_pkg::*, apb_pkg::*; #(
  parameter int addr_width     = 16,  // APB address space in bits
  parameter int register_rdata = 1,   // 1 adds an ending cycle, hrdata from a flop
  parameter int register_wdata = 0    // 1 registers hwdata before setup
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  pclken,     // APB clock enable in HCLK domain
  input  ahb_addr_phase_t       ahb,
  input  logic [data_width-1:0] hwdata,
  output logic                  hreadyout,
  output logic [data_width-1:0] hrdata,
  output logic                  hresp,
  output apb_req_t              apb_req,
  input  apb_rsp_t              apb_rsp,
  output logic                  apbactive   // Clock gating hint for APB
);

  logic                  select;
  logic                  wdata_first;
  logic                  access_done;
  logic                  busy;
  logic                  psel;
  logic                  penable;
  logic [data_width-1:0] pwdata;
  apb_xfer_t             xfer;  // Captured transfer

  // ----------------------------------------
  // Stages
  // ----------------------------------------
  ahb_addr_capture #(
    .addr_width     (addr_width),
    .register_wdata (register_wdata)
  ) u_capture (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .ahb         (ahb),
    .select      (select),
    .wdata_first (wdata_first),
    .xfer        (xfer)
  );

  apb_transfer_fsm #(
    .register_rdata (register_rdata)
  ) u_fsm (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .select      (select),
    .wdata_first (wdata_first),
    .pclken      (pclken),
    .rsp         (apb_rsp),
    .psel        (psel),
    .penable     (penable),
    .hreadyout   (hreadyout),
    .hresp       (hresp),
    .access_done (access_done),
    .busy        (busy)
  );

  bridge_data_regs #(
    .register_rdata (register_rdata),
    .register_wdata (register_wdata)
  ) u_data (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .wdata_first (wdata_first),
    .access_done (access_done),
    .pclken      (pclken),
    .hwdata      (hwdata),
    .prdata      (apb_rsp.prdata),
    .pwdata      (pwdata),
    .hrdata      (hrdata)
  );

  // ----------------------------------------
  // APB request and activity
  // ----------------------------------------
  assign apb_req = '{
    paddr   : {xfer.word_addr, 2'b00},  // Always word aligned
    psel    : psel,
    penable : penable,
    pwrite  : xfer.write,
    pstrb   : xfer.strb,
    pprot   : xfer.prot,
    pwdata  : pwdata
  };

  // Raised already in the address phase so the APB clock can wake up
  assign apbactive = (ahb.sel & ahb.trans[1]) | busy;

  // An accepted address phase always stalls the following data phase
  a_start_stalls : assert property (@(posedge HCLK) disable iff (!HRESETn)
    select |=> !hreadyout)
    else $error("data phase not stalled after transfer start");

endmodule

//--- tests/apb_slave_model.sv
/*
  Reactive APB slave for the bridge testbench
  - one wait state when address bit 2 is set
  - pslverr in the top 256 bytes
  - read data from the word address, last write recorded
*/
module apb_slave_model import ahb_pkg::*, apb_pkg::*; #(
  parameter int          addr_width = 16,
  parameter logic [31:0] rdata_key  = 32'h0000_0000  // XOR pattern for read data
) (
  input  logic                  HCLK,
  input  logic                  HRESETn,
  input  logic                  pclken,
  input  apb_req_t              req,
  output apb_rsp_t              rsp,
  output logic [data_width-1:0] last_wdata,
  output logic [3:0]            last_strb
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [addr_width-1:0] addr;
  logic                  access;  // APB access phase
  logic                  waited;  // Wait state already given

  assign addr   = req.paddr[addr_width-1:0];
  assign access = req.psel & req.penable;

  assign rsp = '{
    prdata  : data_width'(addr >> 2) ^ rdata_key,  // Word address based
    pready  : ~(addr[2] & ~waited),
    pslverr : &addr[addr_width-1:8]                // Top 256 bytes
  };

  // ----------------------------------------
  // Wait state and write capture
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      waited <= 1'b0;
    else if (!access)
      waited <= 1'b0;
    else if (pclken)
      waited <= 1'b1;  // Only APB edges count
  end

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      last_wdata <= '0;
      last_strb  <= '0;
    end
    else if (access && pclken && rsp.pready && req.pwrite && !rsp.pslverr)
    begin
      last_wdata <= req.pwdata;
      last_strb  <= req.pstrb;
    end
  end

endmodule

//--- tests/tb_ahb_to_apb.sv
/*
  Bridge testbench
  - clock, reset, pclken pattern and AHB transfer tasks
  - concurrent checks of APB mapping, read data, ERROR and apbactive
  - watchdog and result summary
*/
module tb_ahb_to_apb import ahb_pkg::*, apb_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int          n_xfers   = 42;             // Sum of all test lengths below
  localparam logic [31:0] rdata_key = 32'hC3A5_5A3C;  // Slave read data pattern

  logic            HCLK;
  logic            HRESETn;
  logic            pclken;
  logic            pclken_toggle;  // Runs the APB side at half rate
  ahb_addr_phase_t ahb_drv;        // Master side, ready comes from the bridge
  ahb_addr_phase_t ahb;
  logic [31:0]     hwdata;
  logic            hreadyout;
  logic            hresp;
  logic [31:0]     hrdata;
  apb_req_t        apb_req;
  apb_rsp_t        apb_rsp;
  logic            apbactive;
  logic [31:0]     slv_wdata;      // Last write seen by the slave
  logic [3:0]      slv_strb;
  logic [31:0]     cur_addr;       // Transfer now in its data phase
  hsize_e          cur_size;
  logic [3:0]      cur_prot;
  logic [31:0]     cur_data;
  logic            dphase_rd;
  logic            dphase_wr;
  logic [15:0]     lfsr;
  int              err_count;
  int              n_done;
  logic [31:0]     exp_paddr;
  logic [31:0]     exp_rdata;
  logic [3:0]      exp_strb;
  logic [2:0]      exp_prot;

  always_comb
  begin
    ahb       = ahb_drv;
    ahb.ready = hreadyout;  // Single slave, HREADY is our own hreadyout
  end

  ahb_to_apb_bridge dut0 (.HCLK, .HRESETn, .pclken, .ahb, .hwdata, .hreadyout, .hrdata,
                          .hresp, .apb_req, .apb_rsp, .apbactive);

  apb_slave_model #(.addr_width(16), .rdata_key(rdata_key)) u_slave (.HCLK, .HRESETn,
    .pclken, .req(apb_req), .rsp(apb_rsp), .last_wdata(slv_wdata), .last_strb(slv_strb));

  always #4 HCLK = ~HCLK;
  always @(negedge HCLK) pclken <= pclken_toggle ? ~pclken : 1'b1;

  // ----------------------------------------
  // Expected values
  // ----------------------------------------
  // Lanes covered by a transfer of the given size, aligned down to that size
  function automatic logic [3:0] lane_mask(input logic [31:0] addr, input hsize_e size);
    int         nbytes;
    int         first;
    logic [3:0] m;
    nbytes = 1 << int'(size);
    first  = int'(addr[1:0]) & ~(nbytes - 1);
    for (int i = 0; i < 4; i++)
      m[i] = (i >= first) && (i < first + nbytes);
    return m;
  endfunction

  assign exp_paddr = {16'h0000, cur_addr[15:2], 2'b00};  // 16-bit APB space
  assign exp_rdata = 32'(cur_addr[15:2]) ^ rdata_key;
  assign exp_prot  = {~cur_prot[0], 1'b0, cur_prot[1]};  // Instruction, secure, privileged
  assign exp_strb  = lane_mask(cur_addr, cur_size);

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);  // Galois step
    end
    return v;
  endfunction

  task automatic value_mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
    $display("[FAIL] %0d ns %s got %h expected %h", $time, sig, got, exp);
    err_count++;
  endtask

  task automatic protocol_problem(input string what);
    $display("At %0d ns %s", $time, what);
    err_count++;
  endtask

  // ----------------------------------------
  // AHB master
  // ----------------------------------------
  task automatic transfer(input logic wr, input logic [31:0] addr, input hsize_e size,
                          input logic [3:0] prot, input logic [31:0] data);
    @(negedge HCLK);  // Bridge idle here
    dphase_rd = 1'b0;
    dphase_wr = 1'b0;
    cur_addr  = addr;
    cur_size  = size;
    cur_prot  = prot;
    cur_data  = data;
    ahb_drv   <= '{sel: 1'b1, addr: addr, trans: trans_nonseq, size: size, prot: prot,
                   write: wr, ready: 1'b1};
    @(negedge HCLK);  // Address phase taken on the edge before
    ahb_drv.sel   <= 1'b0;
    ahb_drv.trans <= trans_idle;
    hwdata        <= data;  // Held through the whole data phase
    dphase_rd     = !wr;
    dphase_wr     = wr;
    while (!hreadyout)
      @(negedge HCLK);
    n_done++;
  endtask

  task automatic run_test(input string name, input int n, input logic wr, input logic err_area);
    int          errs_before;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  prot;
    hsize_e      size;
    errs_before = err_count;
    repeat (n)
    begin
      addr = take_bits(32);
      if (err_area)
        addr[15:8] = 8'hFF;  // Top 256 bytes answer with pslverr
      else if (&addr[15:8])
        addr[8] = 1'b0;
      size = hsize_e'(3'(take_bits(2) % 3));
      prot = 4'(take_bits(4));
      data = take_bits(32);
      transfer(wr, addr, size, prot, data);
    end
    $display("%s: %0d transfers, %0d errors", name, n, err_count - errs_before);
  endtask

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  a_reset_state : assert property (@(posedge HCLK) $rose(HRESETn) |->
    hreadyout && !apb_req.psel && !apb_req.penable && !hresp && !apbactive)
    else protocol_problem("bridge outputs not idle around reset");
  a_paddr : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dphase_rd || dphase_wr) && apb_req.penable |-> apb_req.paddr == exp_paddr)
    else value_mismatch("paddr", $sampled(apb_req.paddr), exp_paddr);
  a_pwrite : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dphase_rd || dphase_wr) && apb_req.penable |-> apb_req.pwrite == dphase_wr)
    else value_mismatch("pwrite", $sampled(apb_req.pwrite), dphase_wr);
  a_pstrb_wr : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_wr && apb_req.penable |-> apb_req.pstrb == exp_strb)
    else value_mismatch("pstrb", $sampled(apb_req.pstrb), exp_strb);
  a_pstrb_rd : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_rd && apb_req.psel |-> apb_req.pstrb == 4'b0000)
    else value_mismatch("pstrb", $sampled(apb_req.pstrb), 0);
  a_pprot : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dphase_rd || dphase_wr) && apb_req.penable |-> apb_req.pprot == exp_prot)
    else value_mismatch("pprot", $sampled(apb_req.pprot), exp_prot);
  a_pwdata : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_wr && apb_req.penable |-> apb_req.pwdata == cur_data)
    else value_mismatch("pwdata", $sampled(apb_req.pwdata), cur_data);
  a_slave_wdata : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_wr && hreadyout && !hresp |-> slv_wdata == cur_data)
    else value_mismatch("slave pwdata", $sampled(slv_wdata), cur_data);
  a_slave_strb : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_wr && hreadyout && !hresp |-> slv_strb == exp_strb)
    else value_mismatch("slave pstrb", $sampled(slv_strb), exp_strb);
  a_hrdata : assert property (@(posedge HCLK) disable iff (!HRESETn)
    dphase_rd && hreadyout && !hresp |-> hrdata == exp_rdata)
    else value_mismatch("hrdata", $sampled(hrdata), exp_rdata);
  a_hresp : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (dphase_rd || dphase_wr) && hreadyout |-> hresp == &cur_addr[15:8])
    else value_mismatch("hresp", $sampled(hresp), &cur_addr[15:8]);
  a_err_shape : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $rose(hresp) |-> !hreadyout ##1 (hresp && hreadyout) ##1 !hresp)
    else protocol_problem("ERROR response is not two cycles with hreadyout low then high");
  a_pclken_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !pclken |=> $stable(apb_req.psel) && $stable(apb_req.penable))
    else protocol_problem("psel or penable moved after an edge with pclken low");
  a_active : assert property (@(posedge HCLK) disable iff (!HRESETn)
    apb_req.psel || !hreadyout || (ahb.sel && ahb.trans[1]) |-> apbactive)
    else protocol_problem("apbactive low while the bridge is in use");

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial
  begin
    HCLK          = 1'b0;
    HRESETn       = 1'b0;
    pclken        = 1'b1;
    pclken_toggle = 1'b0;
    ahb_drv       = '{trans: trans_idle, size: size_word, default: '0};
    hwdata        = '0;
    cur_addr      = '0;
    cur_prot      = '0;
    cur_data      = '0;
    dphase_rd     = 1'b0;
    dphase_wr     = 1'b0;
    cur_size      = size_word;
    lfsr          = 16'd53622;
    err_count     = 0;
    n_done        = 0;
    repeat (4) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn <= 1'b1;
    repeat (2) @(negedge HCLK);
    $display("reset state: %0d errors", err_count);
    run_test("writes", 12, 1'b1, 1'b0);
    run_test("reads", 12, 1'b0, 1'b0);
    run_test("error writes", 2, 1'b1, 1'b1);
    run_test("error reads", 2, 1'b0, 1'b1);
    pclken_toggle <= 1'b1;
    run_test("pclken writes", 6, 1'b1, 1'b0);
    run_test("pclken reads", 6, 1'b0, 1'b0);
    run_test("pclken errors", 2, 1'b1, 1'b1);
    pclken_toggle <= 1'b0;
    @(negedge HCLK);
    dphase_rd = 1'b0;
    dphase_wr = 1'b0;
    repeat (4) @(negedge HCLK);
    $display("apbactive watched over all %0d transfers", n_done);
    $display("Summary: %0d transfers, %0d errors", n_done, err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // Generous per-transfer budget, half-rate pclken included
  initial
  begin
    #((n_xfers * 40 + 100) * 8);
    $display("Timeout after %0d of %0d transfers", n_done, n_xfers);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- files.f
design/ahb_pkg.sv
design/apb_pkg.sv
design/ahb_addr_capture.sv
design/apb_transfer_fsm.sv
design/bridge_data_regs.sv
design/ahb_to_apb_bridge.sv
tests/apb_slave_model.sv
tests/tb_ahb_to_apb.sv
